//--- bench/pcu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcu_defs.svh"

module pcu_tb
  import pcu_pkg::*;
();

  localparam int CLK_PERIOD = 40;

  // cycle budget per test, the watchdog allows twice the sum
  localparam int RESET_CYCLES    = 40;
  localparam int RW_CYCLES       = 100;
  localparam int PRIV_CYCLES     = 130;
  localparam int COUNT_CYCLES    = 580;
  localparam int MODE_CYCLES     = 90;
  localparam int UNMAPPED_CYCLES = 12;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + RW_CYCLES + PRIV_CYCLES +
                                   COUNT_CYCLES + MODE_CYCLES + UNMAPPED_CYCLES;
  localparam int WATCHDOG_NS     = 2 * TOTAL_CYCLES * CLK_PERIOD;

  logic        clk;
  logic        rst;
  logic        spr_access;
  logic        spr_we;
  logic        spr_re;
  logic [15:0] spr_addr;
  logic [31:0] spr_dat_w;
  logic        spr_sys_mode;
  logic [`PCU_NUM_EVENTS-1:0] events;  // indexed by pcu_event_e
  logic        spr_ack;
  logic [31:0] spr_dat_r;

  logic [31:0] lfsr = 32'h3c57;
  int          errors = 0;
  string       cur_test = "none";

  pcu_top pcu_top_inst (
    .clk                       (clk),
    .rst                       (rst),
    .spr_access_i              (spr_access),
    .spr_we_i                  (spr_we),
    .spr_re_i                  (spr_re),
    .spr_addr_i                (spr_addr),
    .spr_dat_i                 (spr_dat_w),
    .spr_ack_o                 (spr_ack),
    .spr_dat_o                 (spr_dat_r),
    .spr_sys_mode_i            (spr_sys_mode),
    .pcu_event_load_i          (events[EV_LOAD]),
    .pcu_event_store_i         (events[EV_STORE]),
    .pcu_event_ifetch_i        (events[EV_IFETCH]),
    .pcu_event_dcache_miss_i   (events[EV_DCACHE_MISS]),
    .pcu_event_icache_miss_i   (events[EV_ICACHE_MISS]),
    .pcu_event_ifetch_stall_i  (events[EV_IFETCH_STALL]),
    .pcu_event_lsu_stall_i     (events[EV_LSU_STALL]),
    .pcu_event_brn_stall_i     (events[EV_BRN_STALL]),
    .pcu_event_dtlb_miss_i     (events[EV_DTLB_MISS]),
    .pcu_event_itlb_miss_i     (events[EV_ITLB_MISS]),
    .pcu_event_datadep_stall_i (events[EV_DDS])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Checks failed");
    $fatal(1, "simulation timed out after %0d ns in test %s", WATCHDOG_NS, cur_test);
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // group 7 in the upper address bits, ignored by the unit
  function automatic logic [15:0] reg_addr(input pcu_reg_kind_e kind, input int k);
    logic [10:0] base;
    base = (kind == REG_PCMR) ? `PCU_PCMR_BASE : `PCU_PCCR_BASE;
    return {5'd7, base + k[10:0]};
  endfunction

  // bits 13:1 writable, bit 0 stuck at one
  function automatic logic [31:0] pcmr_expect(input logic [31:0] w);
    return {18'd0, w[13:1], 1'b1};
  endfunction

  // one access cycle, data sampled mid low phase
  task automatic spr_cycle(input logic we, input logic re, input logic [15:0] addr,
                           input logic [31:0] wdata, input logic sys,
                           output logic [31:0] rdata);
    @(negedge clk);
    spr_access   = 1'b1;
    spr_we       = we;
    spr_re       = re;
    spr_addr     = addr;
    spr_dat_w    = wdata;
    spr_sys_mode = sys;
    #(CLK_PERIOD / 4);
    check(cur_test, 32'd1, {31'd0, spr_ack});
    rdata = spr_dat_r;
    @(negedge clk);
    spr_access = 1'b0;
    spr_we     = 1'b0;
    spr_re     = 1'b0;
  endtask

  task automatic spr_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic sys);
    logic [31:0] unused;
    spr_cycle(1'b1, 1'b0, addr, data, sys, unused);
  endtask

  task automatic spr_read(input logic [15:0] addr, input logic sys,
                          output logic [31:0] data);
    spr_cycle(1'b0, 1'b1, addr, 32'd0, sys, data);
  endtask

  // sparse random events, hits counted against mask
  task automatic run_events(input logic [10:0] mask, input logic sys, input int cycles,
                            output int hits);
    logic [31:0] a;
    logic [31:0] b;
    logic [10:0] vec;
    hits = 0;
    for (int i = 0; i < cycles; i++) begin
      next_bits(11, a);
      next_bits(11, b);
      vec = a[10:0] & b[10:0];
      @(negedge clk);
      spr_sys_mode = sys;
      events       = vec;
      if ((vec & mask) != '0) hits++;  // several events still count once
    end
    @(negedge clk);
    events       = '0;  // idle cycle before the read
    spr_sys_mode = 1'b1;
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    cur_test = "reset_values";
    check(cur_test, 32'd0, {31'd0, spr_ack});  // bus idle
    for (int k = 0; k < `PCU_NUM_COUNTERS; k++) begin
      spr_read(reg_addr(REG_PCCR, k), 1'b1, rd);
      check(cur_test, 32'd0, rd);
      spr_read(reg_addr(REG_PCMR, k), 1'b1, rd);
      check(cur_test, 32'd1, rd);
    end
  endtask

  task automatic test_write_read();
    logic [31:0] rd;
    logic [31:0] wval;
    cur_test = "write_read";
    for (int k = 0; k < `PCU_NUM_COUNTERS; k++) begin
      next_bits(32, wval);
      spr_write(reg_addr(REG_PCCR, k), wval, 1'b1);
      spr_read(reg_addr(REG_PCCR, k), 1'b1, rd);
      check(cur_test, wval, rd);
      spr_write(reg_addr(REG_PCMR, k), 32'hffff_ffff, 1'b1);
      spr_read(reg_addr(REG_PCMR, k), 1'b1, rd);
      check(cur_test, 32'h0000_3fff, rd);
      spr_write(reg_addr(REG_PCMR, k), 32'd0, 1'b1);
      spr_read(reg_addr(REG_PCMR, k), 1'b1, rd);
      check(cur_test, 32'd1, rd);  // CP survives a zero write
    end
  endtask

  task automatic test_privilege();
    logic [31:0] rd;
    logic [31:0] cval;
    logic [31:0] mval;
    cur_test = "privilege";
    for (int k = 0; k < `PCU_NUM_COUNTERS; k++) begin
      next_bits(32, cval);
      next_bits(32, mval);
      spr_write(reg_addr(REG_PCCR, k), cval, 1'b1);
      spr_write(reg_addr(REG_PCMR, k), mval, 1'b1);
      // user writes are acked but dropped
      spr_write(reg_addr(REG_PCCR, k), ~cval, 1'b0);
      spr_write(reg_addr(REG_PCMR, k), ~mval, 1'b0);
      spr_read(reg_addr(REG_PCMR, k), 1'b0, rd);
      check(cur_test, 32'd0, rd);
      spr_read(reg_addr(REG_PCCR, k), 1'b0, rd);
      check(cur_test, cval, rd);
      spr_read(reg_addr(REG_PCMR, k), 1'b1, rd);
      check(cur_test, pcmr_expect(mval), rd);
      spr_read(reg_addr(REG_PCCR, k), 1'b1, rd);
      check(cur_test, cval, rd);
    end
  endtask

  task automatic test_counting();
    logic [31:0] rd;
    logic [31:0] r;
    logic [10:0] mask;
    int          hits;
    cur_test = "event_counting";
    for (int k = 0; k < `PCU_NUM_COUNTERS; k++) begin
      next_bits(11, r);
      mask = (k == 0) ? 11'h7ff : r[10:0];
      if (mask == '0) mask = 11'h001;
      spr_write(reg_addr(REG_PCMR, k), {18'd0, mask, 3'b010}, 1'b1);  // CISM
      spr_write(reg_addr(REG_PCCR, k), 32'd0, 1'b1);
      run_events(mask, 1'b1, 64, hits);
      spr_read(reg_addr(REG_PCCR, k), 1'b1, rd);
      check(cur_test, hits, rd);
    end
  endtask

  task automatic test_mode_filter();
    logic [31:0] rd;
    int          hits;
    cur_test = "mode_filter";
    spr_write(reg_addr(REG_PCMR, 2), {18'd0, 11'h7ff, 3'b100}, 1'b1);  // user only
    spr_write(reg_addr(REG_PCMR, 3), {18'd0, 11'h7ff, 3'b010}, 1'b1);  // supervisor only
    spr_write(reg_addr(REG_PCCR, 2), 32'd0, 1'b1);
    spr_write(reg_addr(REG_PCCR, 3), 32'd0, 1'b1);
    run_events(11'h7ff, 1'b1, 32, hits);
    spr_read(reg_addr(REG_PCCR, 2), 1'b1, rd);
    check(cur_test, 32'd0, rd);
    spr_read(reg_addr(REG_PCCR, 3), 1'b1, rd);
    check(cur_test, hits, rd);
    spr_write(reg_addr(REG_PCCR, 2), 32'd0, 1'b1);
    spr_write(reg_addr(REG_PCCR, 3), 32'd0, 1'b1);
    run_events(11'h7ff, 1'b0, 32, hits);
    spr_read(reg_addr(REG_PCCR, 2), 1'b1, rd);
    check(cur_test, hits, rd);
    spr_read(reg_addr(REG_PCCR, 3), 1'b1, rd);
    check(cur_test, 32'd0, rd);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    cur_test = "unmapped_and_re";
    spr_read({5'd7, 11'd16}, 1'b1, rd);
    check(cur_test, 32'd0, rd);
    spr_read({5'd7, 11'h7ff}, 1'b1, rd);
    check(cur_test, 32'd0, rd);
    spr_write(reg_addr(REG_PCCR, 0), 32'hdead_beef, 1'b1);
    spr_cycle(1'b0, 1'b0, reg_addr(REG_PCCR, 0), 32'd0, 1'b1, rd);  // re low
    check(cur_test, 32'd0, rd);
    spr_read(reg_addr(REG_PCCR, 0), 1'b1, rd);
    check(cur_test, 32'hdead_beef, rd);
  endtask

  initial begin
    rst          = 1'b1;
    spr_access   = 1'b0;
    spr_we       = 1'b0;
    spr_re       = 1'b0;
    spr_addr     = '0;
    spr_dat_w    = '0;
    spr_sys_mode = 1'b1;
    events       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_write_read();
    test_privilege();
    test_counting();
    test_mode_filter();
    test_unmapped();

    @(negedge clk);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/pcu_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcu_defs.svh"

module pcu_counter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        sys_mode_i,
  input  wire [`PCU_NUM_EVENTS-1:0]  events_i,
  input  wire                        pccr_we_i,
  input  wire                        pcmr_we_i,
  input  wire [31:0]                 wdata_i,
  output logic [31:0]                pccr_o,
  output logic [31:0]                pcmr_o
);

  logic [31:0]                pccr_q;
  logic [31:0]                pcmr_q;
  logic                       mode_en;  // current CPU mode enabled
  logic [`PCU_NUM_EVENTS-1:0] ev_mask;
  logic                       ev_hit;   // any enabled event active
  logic                       count_en;

  assign ev_mask = pcmr_q[`PCMR_EV_MSB:`PCMR_EV_LSB];

  // pick CISM or CIUM by the mode of this cycle
  assign mode_en = sys_mode_i ? pcmr_q[`PCMR_CISM] : pcmr_q[`PCMR_CIUM];

  // several events in one cycle still add one
  assign ev_hit   = |(ev_mask & events_i);
  assign count_en = mode_en && ev_hit;

  // mode register
  always_ff @(posedge clk) begin
    if (rst) begin
      pcmr_q <= `PCMR_RESET;
    end else if (pcmr_we_i) begin
      pcmr_q <= (wdata_i & `PCMR_WR_MASK) | `PCMR_RESET;  // keep CP set
    end
  end

  // counter register
  // a software write beats a count in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pccr_q <= '0;
    end else if (pccr_we_i) begin
      pccr_q <= wdata_i;
    end else if (count_en) begin
      pccr_q <= pccr_q + 32'd1;  // wraps at 32 bits
    end
  end

  assign pccr_o = pccr_q;
  assign pcmr_o = pcmr_q;

  // counter present bit never drops, whatever software writes
  cp_set_a: assert property (@(posedge clk) disable iff (rst)
                             pcmr_o[`PCMR_CP])
    else $error("pcu_counter: PCMR CP bit cleared");

  // watchpoint event field stays unimplemented
  wpe_zero_a: assert property (@(posedge clk) disable iff (rst)
                               pcmr_o[31:(`PCMR_EV_MSB + 1)] == '0)
    else $error("pcu_counter: PCMR watchpoint bits set");

endmodule

`default_nettype wire

//--- design/pcu_pkg.sv
`default_nettype none

package pcu_pkg;

  // event indices, order of the packed event vector and of the PCMR enables
  typedef enum logic [3:0] {
    EV_LOAD         = 4'd0,
    EV_STORE        = 4'd1,
    EV_IFETCH       = 4'd2,
    EV_DCACHE_MISS  = 4'd3,
    EV_ICACHE_MISS  = 4'd4,
    EV_IFETCH_STALL = 4'd5,
    EV_LSU_STALL    = 4'd6,
    EV_BRN_STALL    = 4'd7,
    EV_DTLB_MISS    = 4'd8,
    EV_ITLB_MISS    = 4'd9,
    EV_DDS          = 4'd10  // data-dependency stall
  } pcu_event_e;

  // decoded target of an SPR access
  typedef enum logic [1:0] {
    REG_NONE = 2'd0,
    REG_PCCR = 2'd1,
    REG_PCMR = 2'd2
  } pcu_reg_kind_e;

  // decoded SPR operation
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } spr_op_e;

endpackage

`default_nettype wire

//--- design/pcu_spr_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcu_defs.svh"

module pcu_spr_port
  import pcu_pkg::*;
(
  input  wire                                  spr_access_i,
  input  wire                                  spr_we_i,
  input  wire                                  spr_re_i,
  input  wire [15:0]                           spr_addr_i,
  input  wire [31:0]                           spr_dat_i,
  input  wire                                  spr_sys_mode_i,
  input  wire [`PCU_NUM_COUNTERS-1:0][31:0]    pccr_i,
  input  wire [`PCU_NUM_COUNTERS-1:0][31:0]    pcmr_i,
  output logic                                 spr_ack_o,
  output logic [31:0]                          spr_dat_o,
  output logic [`PCU_NUM_COUNTERS-1:0]         pccr_we_o,
  output logic [`PCU_NUM_COUNTERS-1:0]         pcmr_we_o,
  output logic [31:0]                          wdata_o
);

  logic [`PCU_OFFSET_BITS-1:0] offset;
  logic [`PCU_OFFSET_BITS-1:0] pccr_rel;  // offset relative to PCCR0
  logic [`PCU_OFFSET_BITS-1:0] pcmr_rel;  // offset relative to PCMR0
  pcu_reg_kind_e               kind;
  logic [`PCU_IDX_BITS-1:0]    idx;
  spr_op_e                     op;
  logic                        wr_ok;

  // group bits above the offset are decoded by the core
  assign offset   = spr_addr_i[`PCU_OFFSET_BITS-1:0];
  assign pccr_rel = offset - `PCU_PCCR_BASE;
  assign pcmr_rel = offset - `PCU_PCMR_BASE;

  // offsets below a base wrap to large values and fall out of range
  always_comb begin
    kind = REG_NONE;
    idx  = '0;
    if (pccr_rel < `PCU_NUM_COUNTERS) begin
      kind = REG_PCCR;
      idx  = pccr_rel[`PCU_IDX_BITS-1:0];
    end else if (pcmr_rel < `PCU_NUM_COUNTERS) begin
      kind = REG_PCMR;
      idx  = pcmr_rel[`PCU_IDX_BITS-1:0];
    end
  end

  // write has priority when both enables are up
  always_comb begin
    if (!spr_access_i) begin
      op = OP_NONE;
    end else if (spr_we_i) begin
      op = OP_WRITE;
    end else if (spr_re_i) begin
      op = OP_READ;
    end else begin
      op = OP_NONE;
    end
  end

  assign wr_ok = (op == OP_WRITE) && spr_sys_mode_i;  // user writes are dropped

  always_comb begin
    pccr_we_o = '0;
    pcmr_we_o = '0;
    if (wr_ok) begin
      case (kind)
        REG_PCCR: pccr_we_o[idx] = 1'b1;
        REG_PCMR: pcmr_we_o[idx] = 1'b1;
        default: ;
      endcase
    end
  end

  // read mux
  // PCMR is hidden from user mode, PCCR is not
  always_comb begin
    spr_dat_o = '0;
    if (op == OP_READ) begin
      case (kind)
        REG_PCCR: spr_dat_o = pccr_i[idx];
        REG_PCMR: begin
          if (spr_sys_mode_i) begin
            spr_dat_o = pcmr_i[idx];
          end
        end
        default: ;
      endcase
    end
  end

  assign wdata_o   = spr_dat_i;     // shared by all counters
  assign spr_ack_o = spr_access_i;  // single-cycle access, no wait states

  // at most one register of the sixteen is written per cycle
  strobe_onehot_a: assert final ($onehot0({pccr_we_o, pcmr_we_o}))
    else $error("pcu_spr_port: more than one write strobe active");

  // strobes only inside a supervisor access
  strobe_priv_a: assert final (({pccr_we_o, pcmr_we_o} == '0) ||
                               (spr_access_i && spr_sys_mode_i))
    else $error("pcu_spr_port: write strobe outside a supervisor access");

endmodule

`default_nettype wire

//--- design/pcu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcu_defs.svh"

module pcu_top
  import pcu_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  // SPR bus
  input  wire         spr_access_i,
  input  wire         spr_we_i,
  input  wire         spr_re_i,
  input  wire [15:0]  spr_addr_i,
  input  wire [31:0]  spr_dat_i,
  output logic        spr_ack_o,
  output logic [31:0] spr_dat_o,

  input  wire         spr_sys_mode_i,  // high in supervisor mode

  // events from the core
  input  wire         pcu_event_load_i,
  input  wire         pcu_event_store_i,
  input  wire         pcu_event_ifetch_i,
  input  wire         pcu_event_dcache_miss_i,
  input  wire         pcu_event_icache_miss_i,
  input  wire         pcu_event_ifetch_stall_i,
  input  wire         pcu_event_lsu_stall_i,
  input  wire         pcu_event_brn_stall_i,
  input  wire         pcu_event_dtlb_miss_i,
  input  wire         pcu_event_itlb_miss_i,
  input  wire         pcu_event_datadep_stall_i
);

  logic [`PCU_NUM_EVENTS-1:0]         events;
  logic [`PCU_NUM_COUNTERS-1:0][31:0] pccr;
  logic [`PCU_NUM_COUNTERS-1:0][31:0] pcmr;
  logic [`PCU_NUM_COUNTERS-1:0]       pccr_we;
  logic [`PCU_NUM_COUNTERS-1:0]       pcmr_we;
  logic [31:0]                        wdata;

  // event vector in pcu_event_e order, matches the PCMR enable bits
  assign events[EV_LOAD]         = pcu_event_load_i;
  assign events[EV_STORE]        = pcu_event_store_i;
  assign events[EV_IFETCH]       = pcu_event_ifetch_i;
  assign events[EV_DCACHE_MISS]  = pcu_event_dcache_miss_i;
  assign events[EV_ICACHE_MISS]  = pcu_event_icache_miss_i;
  assign events[EV_IFETCH_STALL] = pcu_event_ifetch_stall_i;
  assign events[EV_LSU_STALL]    = pcu_event_lsu_stall_i;
  assign events[EV_BRN_STALL]    = pcu_event_brn_stall_i;
  assign events[EV_DTLB_MISS]    = pcu_event_dtlb_miss_i;
  assign events[EV_ITLB_MISS]    = pcu_event_itlb_miss_i;
  assign events[EV_DDS]          = pcu_event_datadep_stall_i;

  pcu_spr_port spr_port_inst (
    .spr_access_i   (spr_access_i),
    .spr_we_i       (spr_we_i),
    .spr_re_i       (spr_re_i),
    .spr_addr_i     (spr_addr_i),
    .spr_dat_i      (spr_dat_i),
    .spr_sys_mode_i (spr_sys_mode_i),
    .pccr_i         (pccr),
    .pcmr_i         (pcmr),
    .spr_ack_o      (spr_ack_o),
    .spr_dat_o      (spr_dat_o),
    .pccr_we_o      (pccr_we),
    .pcmr_we_o      (pcmr_we),
    .wdata_o        (wdata)
  );

  // one PCCR/PCMR pair per slot
  for (genvar k = 0; k < `PCU_NUM_COUNTERS; k++) begin : g_counter
    pcu_counter counter_inst (
      .clk        (clk),
      .rst        (rst),
      .sys_mode_i (spr_sys_mode_i),
      .events_i   (events),
      .pccr_we_i  (pccr_we[k]),
      .pcmr_we_i  (pcmr_we[k]),
      .wdata_i    (wdata),
      .pccr_o     (pccr[k]),
      .pcmr_o     (pcmr[k])
    );
  end

endmodule

`default_nettype wire

//--- include/pcu_defs.svh
`ifndef PCU_DEFS_SVH
`define PCU_DEFS_SVH

// counter/mode register pairs, fixed by the eight-slot SPR map
`define PCU_NUM_COUNTERS 8

// event inputs, one per pcu_event_e entry
`define PCU_NUM_EVENTS 11

// in-group SPR offsets
`define PCU_OFFSET_BITS 11
`define PCU_PCCR_BASE 11'd0  // PCCR0..PCCR7 on 0..7
`define PCU_PCMR_BASE 11'd8  // PCMR0..PCMR7 on 8..15

// width of the counter index inside a register group
`define PCU_IDX_BITS 3

// PCMR bit positions
`define PCMR_CP 0     // counter present, hardwired one
`define PCMR_CISM 1   // count in supervisor mode
`define PCMR_CIUM 2   // count in user mode

// event enables, event i sits on bit PCMR_EV_LSB + i
`define PCMR_EV_LSB 3
`define PCMR_EV_MSB 13

// bits 13:1 take write data
// bits 31:14 are the watchpoint events, not implemented
`define PCMR_WR_MASK 32'h0000_3ffe

// PCMR value after reset, only CP set
`define PCMR_RESET 32'h0000_0001

`endif

//--- sim.f
+incdir+include
design/pcu_pkg.sv
design/pcu_spr_port.sv
design/pcu_counter.sv
design/pcu_top.sv
bench/pcu_tb.sv
